/* all.f */
+incdir+include
design/issue_pkg.sv
design/int_regfile.sv
design/operand_hazard.sv
design/issue_ctrl.sv
design/operand_dispatch.sv
design/issue_read_operands.sv
test/tb_clock_gen.sv
test/issue_checker.sv
test/issue_monitor.sv
test/issue_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f all.f --top-module issue_tb -o issue_sim \
    && ./obj_dir/issue_sim | tee sim.log \
    && grep -q "Simulation completed successfully" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

/* test/issue_tb.sv */
`include "issue_config.svh"

module issue_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import issue_pkg::*;

    localparam int NR_ROWS = 21;

    // stimulus first, then the expected answer
    typedef struct packed {
        issue_instr_t instr;
        fu_t          cl_rs1;
        fu_t          cl_rs2;
        fu_t          cl_rd;
        sb_operand_t  sb1;
        sb_operand_t  sb2;
        logic         alu_rdy;
        logic         lsu_rdy;
        logic         flush;
        commit_port_t commit;
        logic         exp_ack;
        fu_t          exp_unit;
        logic         check_ops;
        xlen_t        exp_a;
        xlen_t        exp_b;
    } row_t;

    logic clk;
    logic rst_n;
    logic flush;
    issue_instr_t instr;
    logic issue_valid;
    logic issue_ack;
    reg_addr_t rs1;
    reg_addr_t rs2;
    sb_operand_t rs1_sb;
    sb_operand_t rs2_sb;
    clobber_table_t clobber;
    commit_port_t [`ISSUE_NR_COMMIT-1:0] commit;
    logic alu_ready;
    logic lsu_ready;
    fu_data_t fu_data;
    xlen_t pc;
    logic alu_valid;
    logic branch_valid;
    logic mult_valid;
    logic lsu_valid;
    logic csr_valid;

    row_t  rows [NR_ROWS];
    string names [NR_ROWS];
    row_t  cur;
    string cur_name;
    logic  active;
    int    n_rows;
    int    pass_cnt;
    int    fail_cnt;
    // expected register file contents
    xlen_t model [`ISSUE_NR_REGS];
    logic [31:0] rng;

    tb_clock_gen clock_gen_inst (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    issue_read_operands issue_read_operands_inst (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .flush_i        (flush),
        .issue_instr_i  (instr),
        .issue_valid_i  (issue_valid),
        .issue_ack_o    (issue_ack),
        .rs1_o          (rs1),
        .rs2_o          (rs2),
        .rs1_sb_i       (rs1_sb),
        .rs2_sb_i       (rs2_sb),
        .clobber_i      (clobber),
        .commit_i       (commit),
        .alu_ready_i    (alu_ready),
        .lsu_ready_i    (lsu_ready),
        .fu_data_o      (fu_data),
        .pc_o           (pc),
        .alu_valid_o    (alu_valid),
        .branch_valid_o (branch_valid),
        .mult_valid_o   (mult_valid),
        .lsu_valid_o    (lsu_valid),
        .csr_valid_o    (csr_valid)
    );

    bind issue_read_operands issue_checker issue_checker_inst (.*);

    issue_monitor monitor_inst (
        .clk_i       (clk),
        .active_i    (active),
        .name_i      (cur_name),
        .exp_ack_i   (cur.exp_ack),
        .exp_unit_i  (cur.exp_unit),
        .check_ops_i (cur.check_ops),
        .exp_a_i     (cur.exp_a),
        .exp_b_i     (cur.exp_b),
        .exp_instr_i (cur.instr),
        .issue_ack_i (issue_ack),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .fu_data_i   (fu_data),
        .pc_i        (pc),
        .valids_i    ({alu_valid, branch_valid, mult_valid, lsu_valid, csr_valid}),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic xlen_t next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // --------------------
    // table rows
    // --------------------
    // free registers, all units ready, operands straight from the file
    function automatic row_t base_row(input fu_t fu, input reg_addr_t a,
                                      input reg_addr_t b, input reg_addr_t d);
        row_t r;
        r = '0;
        r.instr.pc       = next_rand();
        r.instr.fu       = fu;
        r.instr.op       = fu_op_t'(next_rand());
        r.instr.rs1      = a;
        r.instr.rs2      = b;
        r.instr.rd       = d;
        r.instr.imm      = next_rand();
        r.instr.trans_id = trans_id_t'(n_rows);
        r.alu_rdy        = 1'b1;
        r.lsu_rdy        = 1'b1;
        r.exp_ack        = 1'b1;
        r.exp_unit       = (fu == fu_store) ? fu_load : fu;
        r.check_ops      = 1'b1;
        r.exp_a          = model[a];
        r.exp_b          = model[b];
        return r;
    endfunction

    // row that raises no unit valid, with or without ack
    function automatic row_t no_valid(input row_t r, input logic ack);
        row_t o;
        o = r;
        o.exp_ack   = ack;
        o.exp_unit  = fu_none;
        o.check_ops = 1'b0;
        return o;
    endfunction

    task automatic push(input string name, input row_t r);
        names[n_rows] = name;
        rows[n_rows]  = r;
        n_rows++;
    endtask

    task automatic build_table();
        row_t r;
        push("alu_reg", base_row(fu_alu, 5'd5, 5'd6, 5'd7));
        r = base_row(fu_alu, 5'd8, 5'd10, 5'd11);
        r.instr.use_imm = 1'b1;
        r.exp_b = r.instr.imm;
        push("alu_imm", r);
        r = base_row(fu_alu, 5'd2, 5'd3, 5'd4);
        r.instr.use_pc = 1'b1;
        r.exp_a = r.instr.pc;
        push("alu_pc", r);
        // zimm hides the rs1 clobber
        r = base_row(fu_alu, 5'd9, 5'd12, 5'd13);
        r.instr.use_zimm = 1'b1;
        r.cl_rs1 = fu_load;
        r.exp_a = 32'd9;
        push("alu_zimm", r);
        push("alu_x0", base_row(fu_alu, 5'd0, 5'd0, 5'd14));
        // both sources come from the scoreboard
        r = base_row(fu_alu, 5'd15, 5'd16, 5'd17);
        r.cl_rs1 = fu_load;
        r.cl_rs2 = fu_mult;
        r.sb1 = '{valid: 1'b1, value: next_rand()};
        r.sb2 = '{valid: 1'b1, value: next_rand()};
        r.exp_a = r.sb1.value;
        r.exp_b = r.sb2.value;
        push("fwd_both", r);
        r = base_row(fu_alu, 5'd15, 5'd16, 5'd17);
        r.cl_rs1 = fu_alu;
        push("stall_sb", no_valid(r, 1'b0));
        r.cl_rs1 = fu_csr;
        r.sb1 = '{valid: 1'b1, value: next_rand()};
        push("stall_csr", no_valid(r, 1'b0));
        r = base_row(fu_alu, 5'd18, 5'd19, 5'd20);
        r.cl_rd = fu_mult;
        push("waw_block", no_valid(r, 1'b0));
        r.commit = '{we: 1'b1, waddr: 5'd20, wdata: next_rand()};
        push("waw_commit", r);
        model[20] = r.commit.wdata;
        r = base_row(fu_load, 5'd21, 5'd22, 5'd23);
        r.instr.use_imm = 1'b1;
        r.exp_b = r.instr.imm;
        push("load", r);
        r.lsu_rdy = 1'b0;
        push("load_busy", no_valid(r, 1'b0));
        // stores and branches keep rs2 in operand b
        r = base_row(fu_store, 5'd24, 5'd25, 5'd26);
        r.instr.use_imm = 1'b1;
        push("store", r);
        r = base_row(fu_ctrl_flow, 5'd1, 5'd30, 5'd0);
        r.instr.use_imm = 1'b1;
        push("branch", r);
        push("csr", base_row(fu_csr, 5'd27, 5'd28, 5'd29));
        r = base_row(fu_alu, 5'd5, 5'd6, 5'd7);
        r.flush = 1'b1;
        push("flush", no_valid(r, 1'b1));
        r = base_row(fu_alu, 5'd5, 5'd6, 5'd7);
        r.instr.ex_valid = 1'b1;
        r.alu_rdy = 1'b0;
        r.cl_rs1 = fu_alu;
        push("exception", no_valid(r, 1'b1));
        r = base_row(fu_none, 5'd5, 5'd6, 5'd7);
        r.alu_rdy = 1'b0;
        r.cl_rs2 = fu_alu;
        push("no_unit", no_valid(r, 1'b1));
        push("mult", base_row(fu_mult, 5'd30, 5'd31, 5'd1));
        // issued while the first multiply is still in flight
        push("mult_again", base_row(fu_mult, 5'd3, 5'd4, 5'd2));
        push("alu_after_mult", no_valid(base_row(fu_alu, 5'd5, 5'd6, 5'd7), 1'b0));
    endtask

    // --------------------
    // drivers
    // --------------------
    task automatic drive_idle();
        clobber_table_t t;
        for (int i = 0; i < `ISSUE_NR_REGS; i++) begin
            t[i] = fu_none;
        end
        issue_valid <= 1'b0;
        instr       <= '0;
        clobber     <= t;
        rs1_sb      <= '0;
        rs2_sb      <= '0;
        commit      <= '0;
        alu_ready   <= 1'b1;
        lsu_ready   <= 1'b1;
        flush       <= 1'b0;
        active      <= 1'b0;
    endtask

    task automatic apply_row(input row_t r, input string name);
        clobber_table_t t;
        for (int i = 0; i < `ISSUE_NR_REGS; i++) begin
            t[i] = fu_none;
        end
        t[r.instr.rd]  = r.cl_rd;
        t[r.instr.rs2] = r.cl_rs2;
        t[r.instr.rs1] = r.cl_rs1;
        issue_valid <= 1'b1;
        instr       <= r.instr;
        clobber     <= t;
        rs1_sb      <= r.sb1;
        rs2_sb      <= r.sb2;
        commit[0]   <= r.commit;
        commit[1]   <= '0;
        alu_ready   <= r.alu_rdy;
        lsu_ready   <= r.lsu_rdy;
        flush       <= r.flush;
        cur         <= r;
        cur_name    <= name;
        active      <= 1'b1;
    endtask

    initial begin : main
        int errs;
        drive_idle();
        cur <= '0;
        n_rows = 0;
        rng = 32'h030fc56e;
        model[0] = '0;
        for (int i = 1; i < `ISSUE_NR_REGS; i++) begin
            model[i] = next_rand();
        end
        @(posedge rst_n);
        // preload two registers per cycle
        for (int r = 1; r < `ISSUE_NR_REGS; r += 2) begin
            @(posedge clk);
            commit[0] <= '{we: 1'b1, waddr: reg_addr_t'(r), wdata: model[r]};
            commit[1] <= '{we: (r + 1 < `ISSUE_NR_REGS), waddr: reg_addr_t'(r + 1),
                           wdata: model[(r + 1) % `ISSUE_NR_REGS]};
        end
        @(posedge clk);
        commit <= '0;
        @(posedge clk);
        build_table();
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            apply_row(rows[i], names[i]);
        end
        @(posedge clk);
        drive_idle();
        repeat (2) @(posedge clk);
        errs = issue_read_operands_inst.issue_checker_inst.err_cnt;
        $display("rows %0d passed %0d failed %0d assertion errors %0d",
                 n_rows, pass_cnt, fail_cnt, errs);
        if ((fail_cnt == 0) && (errs == 0) && (pass_cnt == n_rows)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // budget of 4 cycles per row plus slack for reset and preload
    initial begin : watchdog
        repeat (NR_ROWS * 4 + 100) @(posedge clk);
        $display("timeout: the stimulus table did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* test/issue_monitor.sv */
module issue_monitor (
    input  logic                    clk_i,
    input  logic                    active_i,
    input  string                   name_i,
    input  logic                    exp_ack_i,
    input  issue_pkg::fu_t          exp_unit_i,
    input  logic                    check_ops_i,
    input  issue_pkg::xlen_t        exp_a_i,
    input  issue_pkg::xlen_t        exp_b_i,
    // instruction of the row, for lookup indices and passthrough fields
    input  issue_pkg::issue_instr_t exp_instr_i,
    input  logic                    issue_ack_i,
    input  issue_pkg::reg_addr_t    rs1_i,
    input  issue_pkg::reg_addr_t    rs2_i,
    input  issue_pkg::fu_data_t     fu_data_i,
    input  issue_pkg::xlen_t        pc_i,
    // alu, branch, mult, lsu, csr from msb down
    input  logic [4:0]              valids_i,
    output int                      pass_cnt_o,
    output int                      fail_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import issue_pkg::*;

    int pass_cnt = 0;
    int fail_cnt = 0;
    // row that issued last cycle, its registered outputs are due now
    logic         pend = 1'b0;
    string        pend_name;
    logic         pend_ok;
    logic [2:0]   pend_unit;
    logic         pend_check;
    xlen_t        pend_a;
    xlen_t        pend_b;
    issue_instr_t pend_instr;

    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;

    // lsu shares one code for load and store, 7 flags several valids
    function automatic logic [2:0] unit_code(input logic [4:0] v);
        case (v)
            5'b00000: return fu_none;
            5'b10000: return fu_alu;
            5'b01000: return fu_ctrl_flow;
            5'b00100: return fu_mult;
            5'b00010: return fu_load;
            5'b00001: return fu_csr;
            default:  return 3'd7;
        endcase
    endfunction

    // sample mid cycle, away from the edge where the table drives
    always @(negedge clk_i) begin : compare
        logic [2:0] unit;
        unit = unit_code(valids_i);
        if (pend) begin
            if (unit != pend_unit) begin
                $display("FAIL %s unit expected %0d actual %0d", pend_name, pend_unit, unit);
                pend_ok = 1'b0;
            end
            if (pend_check && (fu_data_i.operand_a !== pend_a)) begin
                $display("FAIL %s operand_a expected %h actual %h",
                         pend_name, pend_a, fu_data_i.operand_a);
                pend_ok = 1'b0;
            end
            if (pend_check && (fu_data_i.operand_b !== pend_b)) begin
                $display("FAIL %s operand_b expected %h actual %h",
                         pend_name, pend_b, fu_data_i.operand_b);
                pend_ok = 1'b0;
            end
            // payload and pc are registered every cycle
            if (pc_i !== pend_instr.pc) begin
                $display("FAIL %s pc expected %h actual %h", pend_name, pend_instr.pc, pc_i);
                pend_ok = 1'b0;
            end
            if ((fu_data_i.fu !== pend_instr.fu) || (fu_data_i.op !== pend_instr.op)
                    || (fu_data_i.imm !== pend_instr.imm)
                    || (fu_data_i.trans_id !== pend_instr.trans_id)) begin
                $display("FAIL %s payload expected %h %h %h %h actual %h %h %h %h",
                         pend_name, pend_instr.fu, pend_instr.op, pend_instr.imm,
                         pend_instr.trans_id, fu_data_i.fu, fu_data_i.op, fu_data_i.imm,
                         fu_data_i.trans_id);
                pend_ok = 1'b0;
            end
            if (pend_ok) begin
                $display("PASS %s", pend_name);
                pass_cnt++;
            end else begin
                fail_cnt++;
            end
        end
        pend = active_i;
        if (active_i) begin
            pend_name  = name_i;
            pend_unit  = exp_unit_i;
            pend_check = check_ops_i;
            pend_a     = exp_a_i;
            pend_b     = exp_b_i;
            pend_instr = exp_instr_i;
            pend_ok    = 1'b1;
            // ack is combinational, so it belongs to this cycle
            if (issue_ack_i !== exp_ack_i) begin
                $display("FAIL %s ack expected %0b actual %0b", name_i, exp_ack_i, issue_ack_i);
                pend_ok = 1'b0;
            end
            // scoreboard lookup indices are combinational too
            if ((rs1_i !== exp_instr_i.rs1) || (rs2_i !== exp_instr_i.rs2)) begin
                $display("FAIL %s lookup expected %0d %0d actual %0d %0d",
                         name_i, exp_instr_i.rs1, exp_instr_i.rs2, rs1_i, rs2_i);
                pend_ok = 1'b0;
            end
        end
    end

endmodule

/* test/issue_checker.sv */
module issue_checker (
    input logic clk_i,
    input logic rst_ni,
    input logic issue_valid_i,
    input logic issue_ack_o,
    input logic alu_valid_o,
    input logic branch_valid_o,
    input logic mult_valid_o,
    input logic lsu_valid_o,
    input logic csr_valid_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench top after the run
    int err_cnt = 0;
    logic [4:0] valids;

    assign valids = {alu_valid_o, branch_valid_o, mult_valid_o, lsu_valid_o, csr_valid_o};

    // --------------------
    // handshake
    // --------------------
    ack_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_ack_o |-> issue_valid_i)
        else begin
            err_cnt++;
            $error("issue ack high while issue valid is low");
        end

    // the ID/EX register feeds one unit at a time
    one_unit_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(valids))
        else begin
            err_cnt++;
            $error("more than one unit valid high");
        end

    // --------------------
    // reset
    // --------------------
    // first edge out of reset must not load a unit valid
    quiet_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |=> (valids == '0))
        else begin
            err_cnt++;
            $error("unit valid high right after reset release");
        end

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset low for the first 4 rising edges
    initial begin
        rst_no = 1'b0;
        repeat (4) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

/* design/issue_read_operands.sv */
`include "issue_config.svh"

module issue_read_operands (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic                                           flush_i,
    // scoreboard issue port
    input  issue_pkg::issue_instr_t                        issue_instr_i,
    input  logic                                           issue_valid_i,
    output logic                                           issue_ack_o,
    // scoreboard operand lookup
    output issue_pkg::reg_addr_t                           rs1_o,
    output issue_pkg::reg_addr_t                           rs2_o,
    input  issue_pkg::sb_operand_t                         rs1_sb_i,
    input  issue_pkg::sb_operand_t                         rs2_sb_i,
    input  issue_pkg::clobber_table_t                      clobber_i,
    // commit writes
    input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0] commit_i,
    // units
    input  logic                                           alu_ready_i,
    input  logic                                           lsu_ready_i,
    output issue_pkg::fu_data_t                            fu_data_o,
    output issue_pkg::xlen_t                               pc_o,
    output logic                                           alu_valid_o,
    output logic                                           branch_valid_o,
    output logic                                           mult_valid_o,
    output logic                                           lsu_valid_o,
    output logic                                           csr_valid_o
);
    import issue_pkg::*;

    xlen_t rdata_a;
    xlen_t rdata_b;
    logic  forward_rs1;
    logic  forward_rs2;
    logic  stall;
    logic  issue_fire;

    assign issue_fire = issue_valid_i && issue_ack_o;

    int_regfile int_regfile_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_instr_i.rs1),
        .raddr_b_i (issue_instr_i.rs2),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .commit_i  (commit_i)
    );

    operand_hazard operand_hazard_inst (
        .issue_instr_i (issue_instr_i),
        .clobber_i     (clobber_i),
        .rs1_sb_i      (rs1_sb_i),
        .rs2_sb_i      (rs2_sb_i),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .forward_rs1_o (forward_rs1),
        .forward_rs2_o (forward_rs2),
        .stall_o       (stall)
    );

    // the registered mult valid doubles as the in-flight flag
    issue_ctrl issue_ctrl_inst (
        .issue_instr_i   (issue_instr_i),
        .issue_valid_i   (issue_valid_i),
        .clobber_i       (clobber_i),
        .commit_i        (commit_i),
        .stall_i         (stall),
        .alu_ready_i     (alu_ready_i),
        .lsu_ready_i     (lsu_ready_i),
        .mult_inflight_i (mult_valid_o),
        .issue_ack_o     (issue_ack_o)
    );

    operand_dispatch operand_dispatch_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .issue_instr_i  (issue_instr_i),
        .issue_fire_i   (issue_fire),
        .rdata_a_i      (rdata_a),
        .rdata_b_i      (rdata_b),
        .rs1_sb_i       (rs1_sb_i),
        .rs2_sb_i       (rs2_sb_i),
        .forward_rs1_i  (forward_rs1),
        .forward_rs2_i  (forward_rs2),
        .fu_data_o      (fu_data_o),
        .pc_o           (pc_o),
        .alu_valid_o    (alu_valid_o),
        .branch_valid_o (branch_valid_o),
        .mult_valid_o   (mult_valid_o),
        .lsu_valid_o    (lsu_valid_o),
        .csr_valid_o    (csr_valid_o)
    );

endmodule

/* design/operand_dispatch.sv */
module operand_dispatch (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  logic                    issue_fire_i,
    input  issue_pkg::xlen_t        rdata_a_i,
    input  issue_pkg::xlen_t        rdata_b_i,
    input  issue_pkg::sb_operand_t  rs1_sb_i,
    input  issue_pkg::sb_operand_t  rs2_sb_i,
    input  logic                    forward_rs1_i,
    input  logic                    forward_rs2_i,
    output issue_pkg::fu_data_t     fu_data_o,
    output issue_pkg::xlen_t        pc_o,
    output logic                    alu_valid_o,
    output logic                    branch_valid_o,
    output logic                    mult_valid_o,
    output logic                    lsu_valid_o,
    output logic                    csr_valid_o
);
    import issue_pkg::*;

    // one bit per unit, at most one set
    typedef struct packed {
        logic alu;
        logic branch;
        logic mult;
        logic lsu;
        logic csr;
    } unit_valid_t;

    fu_data_t    fu_data_d, fu_data_q;
    unit_valid_t valid_d, valid_q;
    xlen_t       pc_q;

    // --------------------
    // operand select
    // --------------------
    always_comb begin
        fu_data_d.fu       = issue_instr_i.fu;
        fu_data_d.op       = issue_instr_i.op;
        fu_data_d.imm      = issue_instr_i.imm;
        fu_data_d.trans_id = issue_instr_i.trans_id;

        // later checks override earlier ones
        fu_data_d.operand_a = forward_rs1_i ? rs1_sb_i.value : rdata_a_i;
        if (issue_instr_i.use_pc) begin
            fu_data_d.operand_a = issue_instr_i.pc;
        end
        if (issue_instr_i.use_zimm) begin
            fu_data_d.operand_a = xlen_t'(issue_instr_i.rs1);
        end

        fu_data_d.operand_b = forward_rs2_i ? rs2_sb_i.value : rdata_b_i;
        // stores and branches still need rs2, their imm rides in the imm field
        if (issue_instr_i.use_imm && (issue_instr_i.fu != fu_store)
                && (issue_instr_i.fu != fu_ctrl_flow)) begin
            fu_data_d.operand_b = issue_instr_i.imm;
        end
    end

    // --------------------
    // unit valid decode
    // --------------------
    always_comb begin
        valid_d = '0;
        if (issue_fire_i && !issue_instr_i.ex_valid && !flush_i) begin
            case (issue_instr_i.fu)
                fu_alu:            valid_d.alu    = 1'b1;
                fu_ctrl_flow:      valid_d.branch = 1'b1;
                fu_mult:           valid_d.mult   = 1'b1;
                fu_load, fu_store: valid_d.lsu    = 1'b1;
                fu_csr:            valid_d.csr    = 1'b1;
                default:           valid_d        = '0;
            endcase
        end
    end

    // ID/EX register, payload follows the issue port every cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_q    <= '0;
            fu_data_q.fu <= fu_none;
            valid_q      <= '0;
            pc_q         <= '0;
        end else begin
            fu_data_q <= fu_data_d;
            valid_q   <= valid_d;
            pc_q      <= issue_instr_i.pc;
        end
    end

    assign fu_data_o      = fu_data_q;
    assign pc_o           = pc_q;
    assign alu_valid_o    = valid_q.alu;
    assign branch_valid_o = valid_q.branch;
    assign mult_valid_o   = valid_q.mult;
    assign lsu_valid_o    = valid_q.lsu;
    assign csr_valid_o    = valid_q.csr;

endmodule

/* design/issue_ctrl.sv */
`include "issue_config.svh"

module issue_ctrl (
    input  issue_pkg::issue_instr_t                        issue_instr_i,
    input  logic                                           issue_valid_i,
    input  issue_pkg::clobber_table_t                      clobber_i,
    input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0] commit_i,
    input  logic                                           stall_i,
    input  logic                                           alu_ready_i,
    input  logic                                           lsu_ready_i,
    input  logic                                           mult_inflight_i,
    output logic                                           issue_ack_o
);
    import issue_pkg::*;

    logic fu_busy;
    logic rd_free;
    logic rd_commit;

    // --------------------
    // unit busy select
    // --------------------
    always_comb begin
        case (issue_instr_i.fu)
            fu_alu, fu_ctrl_flow, fu_csr, fu_mult: fu_busy = !alu_ready_i;
            fu_load, fu_store:                     fu_busy = !lsu_ready_i;
            default:                               fu_busy = 1'b0;
        endcase
    end

    // --------------------
    // WAW check
    // --------------------
    assign rd_free = (clobber_i[issue_instr_i.rd] == fu_none);

    // destination retires this cycle, so the old writer is gone
    always_comb begin
        rd_commit = 1'b0;
        for (int i = 0; i < `ISSUE_NR_COMMIT; i++) begin
            if (commit_i[i].we && (commit_i[i].waddr == issue_instr_i.rd)) begin
                rd_commit = 1'b1;
            end
        end
    end

    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall_i && !fu_busy && (rd_free || rd_commit)) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less ops just drain from the scoreboard
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == fu_none)) begin
                issue_ack_o = 1'b1;
            end
        end
        // a multiply in flight blocks all but another multiply
        if (mult_inflight_i && (issue_instr_i.fu != fu_mult)) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

/* design/operand_hazard.sv */
module operand_hazard (
    input  issue_pkg::issue_instr_t   issue_instr_i,
    input  issue_pkg::clobber_table_t clobber_i,
    input  issue_pkg::sb_operand_t    rs1_sb_i,
    input  issue_pkg::sb_operand_t    rs2_sb_i,
    output issue_pkg::reg_addr_t      rs1_o,
    output issue_pkg::reg_addr_t      rs2_o,
    output logic                      forward_rs1_o,
    output logic                      forward_rs2_o,
    output logic                      stall_o
);
    import issue_pkg::*;

    // unit currently owning each source register
    fu_t rs1_owner;
    fu_t rs2_owner;

    // scoreboard lookup uses the raw source indices
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    assign rs1_owner = clobber_i[issue_instr_i.rs1];
    assign rs2_owner = clobber_i[issue_instr_i.rs2];

    // --------------------
    // source checks
    // --------------------
    always_comb begin
        forward_rs1_o = 1'b0;
        forward_rs2_o = 1'b0;
        stall_o       = 1'b0;

        // with zimm the rs1 field is an immediate, nothing to wait for
        if (!issue_instr_i.use_zimm && (rs1_owner != fu_none)) begin
            // csr results only come through the register file
            if (rs1_sb_i.valid && (rs1_owner != fu_csr)) begin
                forward_rs1_o = 1'b1;
            end else begin
                stall_o = 1'b1;
            end
        end

        // rs2 has no immediate alias
        if (rs2_owner != fu_none) begin
            if (rs2_sb_i.valid && (rs2_owner != fu_csr)) begin
                forward_rs2_o = 1'b1;
            end else begin
                stall_o = 1'b1;
            end
        end
    end

endmodule

/* design/int_regfile.sv */
`include "issue_config.svh"

module int_regfile (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  issue_pkg::reg_addr_t                         raddr_a_i,
    input  issue_pkg::reg_addr_t                         raddr_b_i,
    output issue_pkg::xlen_t                             rdata_a_o,
    output issue_pkg::xlen_t                             rdata_b_o,
    input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0] commit_i
);
    import issue_pkg::*;

    // x0 has no storage, the read side returns zero for it
    xlen_t regs_q [1:`ISSUE_NR_REGS-1];

    // --------------------
    // write side
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int r = 1; r < `ISSUE_NR_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            // later ports overwrite earlier ones on the same index
            for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // --------------------
    // read side
    // --------------------
    // no write bypass, a same cycle commit shows up one cycle later
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* design/issue_pkg.sv */
`include "issue_config.svh"

package issue_pkg;

    // --------------------
    // plain vector types
    // --------------------
    typedef logic [`ISSUE_XLEN-1:0] xlen_t;
    typedef logic [$clog2(`ISSUE_NR_REGS)-1:0] reg_addr_t;
    typedef logic [`ISSUE_TRANS_ID_BITS-1:0] trans_id_t;
    // operation code, opaque to this stage
    typedef logic [5:0] fu_op_t;

    // target functional unit, fu_none must stay at code zero
    typedef enum logic [2:0] {
        fu_none,
        fu_load,
        fu_store,
        fu_alu,
        fu_ctrl_flow,
        fu_mult,
        fu_csr
    } fu_t;

    // --------------------
    // bundles
    // --------------------
    // one decoded instruction as presented by the scoreboard
    typedef struct packed {
        xlen_t     pc;
        fu_t       fu;
        fu_op_t    op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        xlen_t     imm;
        trans_id_t trans_id;
        logic      use_imm;
        logic      use_pc;
        logic      use_zimm;
        logic      ex_valid;
    } issue_instr_t;

    // scoreboard answer for one source lookup
    typedef struct packed {
        logic  valid;
        xlen_t value;
    } sb_operand_t;

    // one commit write into the integer register file
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        xlen_t     wdata;
    } commit_port_t;

    // unit still writing each register, fu_none when free
    typedef fu_t [`ISSUE_NR_REGS-1:0] clobber_table_t;

    // ID/EX payload towards the units
    typedef struct packed {
        fu_t       fu;
        fu_op_t    op;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

endpackage

/* include/issue_config.svh */
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// --------------------
// datapath sizing
// --------------------
`define ISSUE_XLEN 32
`define ISSUE_NR_REGS 32

// write ports coming back from the commit stage
`define ISSUE_NR_COMMIT 2
// scoreboard tag width
`define ISSUE_TRANS_ID_BITS 3

`endif
